// File: compile.f
+incdir+design
design/mips_pkg.sv
design/pipe_reg.sv
design/main_decoder.sv
design/reg_file.sv
design/alu.sv
design/operand_bypass.sv
design/mips.sv
sim/mips_assertions.sv
sim/mips_tb.sv

// File: design/alu.sv
`timescale 1ns/1ps

module alu
(
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  mips_pkg::alu_op_e op,
  output mips_pkg::word_t   y
);

  mips_pkg::word_t diff;

  assign diff = a - b;

  always_comb
  begin
    case (op)
      mips_pkg::ALU_ADD: y = a + b;
      mips_pkg::ALU_SUB: y = diff;
      mips_pkg::ALU_AND: y = a & b;
      mips_pkg::ALU_OR:  y = a | b;
      mips_pkg::ALU_SLT: y = mips_pkg::word_t'($signed(a) < $signed(b)); // Signed compare
      default:           y = a + b;
    endcase
  end

endmodule

// File: design/main_decoder.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module main_decoder
(
  input  logic [5:0]      op,
  input  logic [5:0]      funct,
  output mips_pkg::ctrl_t ctrl
);

  always_comb
  begin
    ctrl        = '0;
    ctrl.alu_op = mips_pkg::ALU_ADD;
    case (op)
      `MIPS_OP_LW:
      begin
        ctrl.alusrc   = 1'b1;
        ctrl.signext  = 1'b1;
        ctrl.memread  = 1'b1;
        ctrl.memtoreg = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      `MIPS_OP_SW:
      begin
        ctrl.alusrc   = 1'b1;
        ctrl.signext  = 1'b1;
        ctrl.memwrite = 1'b1;
      end
      `MIPS_OP_ADDI, `MIPS_OP_ADDIU:
      begin
        ctrl.alusrc   = 1'b1;
        ctrl.signext  = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      `MIPS_OP_ORI:
      begin
        ctrl.alusrc   = 1'b1; // Zero extended immediate
        ctrl.regwrite = 1'b1;
        ctrl.alu_op   = mips_pkg::ALU_OR;
      end
      `MIPS_OP_RTYPE:
      begin
        ctrl.regdst   = 1'b1;
        ctrl.regwrite = 1'b1;
        case (funct)
          `MIPS_FN_SUB, `MIPS_FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
          `MIPS_FN_AND:                ctrl.alu_op = mips_pkg::ALU_AND;
          `MIPS_FN_OR:                 ctrl.alu_op = mips_pkg::ALU_OR;
          `MIPS_FN_SLT:                ctrl.alu_op = mips_pkg::ALU_SLT;
          default:                     ctrl.alu_op = mips_pkg::ALU_ADD; // add, addu
        endcase
      end
      default:
      begin
        // Unknown opcode acts as R-type add
        ctrl.regdst   = 1'b1;
        ctrl.regwrite = 1'b1;
      end
    endcase
  end

endmodule

// File: design/mips.sv
`timescale 1ns/1ps
`include "mips_config.svh"

// Five-stage pipelined MIPS integer core
module mips
(
  input  logic            clk,
  input  logic            reset,
  output mips_pkg::word_t pc,
  input  mips_pkg::word_t instr,
  output logic            memwrite,
  output mips_pkg::word_t memaddr,
  output mips_pkg::word_t memwritedata,
  input  mips_pkg::word_t memreaddata
);

  mips_pkg::if_id_t    if_id_d, if_id_q;
  mips_pkg::id_ex_t    id_ex_d, id_ex_q;
  mips_pkg::ex_mem_t   ex_mem_d, ex_mem_q;
  mips_pkg::mem_wb_t   mem_wb_d, mem_wb_q;

  logic                stall;
  mips_pkg::word_t     pc_plus4;
  mips_pkg::ctrl_t     id_ctrl;
  mips_pkg::reg_addr_t id_rs, id_rt, id_rd;
  logic [15:0]         id_imm16;
  mips_pkg::word_t     id_rd1, id_rd2, id_imm;
  mips_pkg::word_t     ex_opa, ex_opb, ex_srcb, ex_aluout;
  mips_pkg::reg_addr_t ex_writereg;
  mips_pkg::word_t     wb_result;

  // ------------------------------------------------------------
  // IF
  // ------------------------------------------------------------
  assign pc_plus4 = pc + mips_pkg::word_t'(4);

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else if (!stall)
      pc <= pc_plus4;   // No control flow, so +4 or hold
  end

  assign if_id_d.instr = instr;

  pipe_reg #(.payload_t(mips_pkg::if_id_t)) if_id
  (
    .clk    (clk),
    .reset  (reset),
    .en     (!stall),
    .bubble (1'b0),
    .d      (if_id_d),
    .q      (if_id_q)
  );

  // ------------------------------------------------------------
  // ID
  // ------------------------------------------------------------
  assign id_rs    = if_id_q.instr[25:21];
  assign id_rt    = if_id_q.instr[20:16];
  assign id_rd    = if_id_q.instr[15:11];
  assign id_imm16 = if_id_q.instr[15:0];

  main_decoder dec0
  (
    .op    (if_id_q.instr[31:26]),
    .funct (if_id_q.instr[5:0]),
    .ctrl  (id_ctrl)
  );

  reg_file rf0
  (
    .clk (clk),
    .we  (mem_wb_q.regwrite),
    .ra1 (id_rs),
    .ra2 (id_rt),
    .wa  (mem_wb_q.writereg),
    .wd  (wb_result),
    .rd1 (id_rd1),
    .rd2 (id_rd2)
  );

  assign id_imm = id_ctrl.signext ? {{(`MIPS_XLEN-16){id_imm16[15]}}, id_imm16}
                                  : {{(`MIPS_XLEN-16){1'b0}}, id_imm16};

  // Load in EX feeding the instruction in ID
  assign stall = id_ex_q.ctrl.memread &&
                 (id_ex_q.rt == id_rs || id_ex_q.rt == id_rt);

  assign id_ex_d = '{ctrl: id_ctrl, srca: id_rd1, srcb: id_rd2, imm: id_imm,
                     rs: id_rs, rt: id_rt, rd: id_rd};

  pipe_reg #(.payload_t(mips_pkg::id_ex_t)) id_ex
  (
    .clk    (clk),
    .reset  (reset),
    .en     (1'b1),
    .bubble (stall),   // Inserts a nop behind the load
    .d      (id_ex_d),
    .q      (id_ex_q)
  );

  // ------------------------------------------------------------
  // EX
  // ------------------------------------------------------------
  operand_bypass byp0
  (
    .ex_rs        (id_ex_q.rs),
    .ex_rt        (id_ex_q.rt),
    .ex_srca      (id_ex_q.srca),
    .ex_srcb      (id_ex_q.srcb),
    .mem_regwrite (ex_mem_q.regwrite),
    .mem_writereg (ex_mem_q.writereg),
    .mem_aluout   (ex_mem_q.aluout),
    .wb_regwrite  (mem_wb_q.regwrite),
    .wb_writereg  (mem_wb_q.writereg),
    .wb_result    (wb_result),
    .opa          (ex_opa),
    .opb          (ex_opb)
  );

  assign ex_srcb     = id_ex_q.ctrl.alusrc ? id_ex_q.imm : ex_opb;
  assign ex_writereg = id_ex_q.ctrl.regdst ? id_ex_q.rd : id_ex_q.rt;

  alu alu0
  (
    .a  (ex_opa),
    .b  (ex_srcb),
    .op (id_ex_q.ctrl.alu_op),
    .y  (ex_aluout)
  );

  assign ex_mem_d = '{memread: id_ex_q.ctrl.memread, memwrite: id_ex_q.ctrl.memwrite,
                      memtoreg: id_ex_q.ctrl.memtoreg, regwrite: id_ex_q.ctrl.regwrite,
                      aluout: ex_aluout, writedata: ex_opb, rt: id_ex_q.rt,
                      writereg: ex_writereg};

  pipe_reg #(.payload_t(mips_pkg::ex_mem_t)) ex_mem
  (
    .clk    (clk),
    .reset  (reset),
    .en     (1'b1),
    .bubble (1'b0),
    .d      (ex_mem_d),
    .q      (ex_mem_q)
  );

  // ------------------------------------------------------------
  // MEM and WB
  // ------------------------------------------------------------
  assign memwrite     = ex_mem_q.memwrite;
  assign memaddr      = ex_mem_q.aluout;
  assign memwritedata = ex_mem_q.writedata;

  assign mem_wb_d = '{memtoreg: ex_mem_q.memtoreg, regwrite: ex_mem_q.regwrite,
                      readdata: memreaddata, aluout: ex_mem_q.aluout,
                      writereg: ex_mem_q.writereg};

  pipe_reg #(.payload_t(mips_pkg::mem_wb_t)) mem_wb
  (
    .clk    (clk),
    .reset  (reset),
    .en     (1'b1),
    .bubble (1'b0),
    .d      (mem_wb_d),
    .q      (mem_wb_q)
  );

  assign wb_result = mem_wb_q.memtoreg ? mem_wb_q.readdata : mem_wb_q.aluout;

endmodule

// File: design/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath sizing
`define MIPS_XLEN   32
`define MIPS_REG_AW 5
`define MIPS_NREGS  32

// Opcodes in instr[31:26]
`define MIPS_OP_RTYPE 6'b000000
`define MIPS_OP_LW    6'b100011
`define MIPS_OP_SW    6'b101011
`define MIPS_OP_ADDI  6'b001000
`define MIPS_OP_ADDIU 6'b001001 // No overflow trap, same as addi here
`define MIPS_OP_ORI   6'b001101

// R-type funct codes in instr[5:0]
`define MIPS_FN_ADD  6'b100000
`define MIPS_FN_ADDU 6'b100001
`define MIPS_FN_SUB  6'b100010
`define MIPS_FN_SUBU 6'b100011
`define MIPS_FN_AND  6'b100100
`define MIPS_FN_OR   6'b100101
`define MIPS_FN_SLT  6'b101010

`endif

// File: design/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

  typedef logic [`MIPS_XLEN-1:0]   word_t;
  typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

  typedef enum logic [2:0]
  {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  // Decode control, produced in ID and carried into EX
  typedef struct packed
  {
    alu_op_e alu_op;
    logic    alusrc;   // Immediate as ALU operand b
    logic    signext;  // Sign extend imm, else zero extend
    logic    regdst;   // Write rd, else rt
    logic    memread;
    logic    memwrite;
    logic    memtoreg;
    logic    regwrite;
  } ctrl_t;

  // ------------------------------------------------------------
  // Stage payloads
  // ------------------------------------------------------------
  typedef struct packed
  {
    word_t instr;
  } if_id_t;

  typedef struct packed
  {
    ctrl_t     ctrl;
    word_t     srca;
    word_t     srcb;
    word_t     imm;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed
  {
    logic      memread;
    logic      memwrite;
    logic      memtoreg;
    logic      regwrite;
    word_t     aluout;
    word_t     writedata;
    reg_addr_t rt;
    reg_addr_t writereg;
  } ex_mem_t;

  typedef struct packed
  {
    logic      memtoreg;
    logic      regwrite;
    word_t     readdata;
    word_t     aluout;
    reg_addr_t writereg;
  } mem_wb_t;

endpackage

// File: design/operand_bypass.sv
`timescale 1ns/1ps

// EX operand forwarding from MEM and WB
module operand_bypass
(
  input  mips_pkg::reg_addr_t ex_rs,
  input  mips_pkg::reg_addr_t ex_rt,
  input  mips_pkg::word_t     ex_srca,
  input  mips_pkg::word_t     ex_srcb,
  input  logic                mem_regwrite,
  input  mips_pkg::reg_addr_t mem_writereg,
  input  mips_pkg::word_t     mem_aluout,
  input  logic                wb_regwrite,
  input  mips_pkg::reg_addr_t wb_writereg,
  input  mips_pkg::word_t     wb_result,
  output mips_pkg::word_t     opa,
  output mips_pkg::word_t     opb
);

  // Newest producer wins, r0 is never forwarded
  function automatic mips_pkg::word_t pick
  (
    input mips_pkg::reg_addr_t src,
    input mips_pkg::word_t     regval
  );
    if (src != '0 && mem_regwrite && mem_writereg == src)
      return mem_aluout;
    else if (src != '0 && wb_regwrite && wb_writereg == src)
      return wb_result;
    return regval;
  endfunction

  always_comb
  begin
    opa = pick(ex_rs, ex_srca);
    opb = pick(ex_rt, ex_srcb);   // Also the store data
  end

endmodule

// File: design/pipe_reg.sv
`timescale 1ns/1ps

// Register between two pipeline stages
module pipe_reg
#(
  parameter type payload_t = logic
)
(
  input  logic     clk,
  input  logic     reset,
  input  logic     en,
  input  logic     bubble,  // Load an all-zero payload
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk)
  begin
    if (reset || bubble)
      q <= '0;           // Zero payload never writes anything
    else if (en)
      q <= d;
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "mips_config.svh"

// Two read ports, one write port; r0 has no storage
module reg_file
(
  input  logic                clk,
  input  logic                we,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  input  mips_pkg::reg_addr_t wa,
  input  mips_pkg::word_t     wd,
  output mips_pkg::word_t     rd1,
  output mips_pkg::word_t     rd2
);

  mips_pkg::word_t regs [1:`MIPS_NREGS-1];

  always_ff @(posedge clk)
  begin
    if (we && wa != '0)
      regs[wa] <= wd;
  end

  // Write-through so WB results reach ID in the same cycle
  assign rd1 = (ra1 == '0)       ? '0 :
               (we && ra1 == wa) ? wd : regs[ra1];
  assign rd2 = (ra2 == '0)       ? '0 :
               (we && ra2 == wa) ? wd : regs[ra2];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mips_tb -f compile.f -o mips_tb_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/mips_tb_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

// File: sim/mips_assertions.sv
`timescale 1ns/1ps

// Output checks on the core, bound to mips
module mips_assertions
(
  input logic            clk,
  input logic            reset,
  input mips_pkg::word_t pc,
  input logic            memwrite,
  input mips_pkg::word_t memaddr,
  input mips_pkg::word_t memwritedata,
  input logic            checking,   // A test is running
  input logic            exp_valid,
  input logic [63:0]     exp_head    // Expected {address, data}
);

  int fail_count = 0;

  // ------------------------------------------------------------
  // Reset behavior
  // ------------------------------------------------------------
  a_reset_state: assert property (@(posedge clk) $fell(reset) |-> (pc == '0 && !memwrite))
  else
  begin
    $error("pc or memwrite not cleared by reset");
    fail_count++;
  end

  a_no_write_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |-> !memwrite)
  else
  begin
    $error("memwrite high while reset is held");
    fail_count++;
  end

  // ------------------------------------------------------------
  // PC sequencing, +4 or a single one-cycle hold
  // ------------------------------------------------------------
  a_pc_step: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> (pc == $past(pc) || pc == $past(pc) + 32'd4))
  else
  begin
    $error("pc neither held nor advanced by 4");
    fail_count++;
  end

  a_single_hold: assert property (@(posedge clk) disable iff (reset)
    (!$past(reset) && pc == $past(pc)) |=> pc != $past(pc))
  else
  begin
    $error("pc held for two cycles in a row");
    fail_count++;
  end

  // Stores in program order against the reference model
  a_store_match: assert property (@(posedge clk) disable iff (reset)
    (checking && memwrite) |-> (exp_valid && {memaddr, memwritedata} == exp_head))
  else
  begin
    $error("store address or data differs from the reference model");
    fail_count++;
  end

endmodule

// File: sim/mips_tb.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_tb;

  logic            clk;
  logic            reset;
  mips_pkg::word_t pc;
  mips_pkg::word_t instr = '0;
  logic            memwrite;
  mips_pkg::word_t memaddr;
  mips_pkg::word_t memwritedata;
  mips_pkg::word_t memreaddata = '0;

  mips_pkg::word_t imem [0:63];
  mips_pkg::word_t dmem [0:63];
  mips_pkg::word_t ref_mem [0:63];   // Reference model data memory
  mips_pkg::word_t ref_regs [0:31];
  mips_pkg::word_t prog_alu[$], prog_lu[$], prog_zero[$], cur_prog[$];

  logic [63:0]     exp_q[$];         // {address, data} per store
  logic [63:0]     exp_head = '0;
  logic            exp_valid = 1'b0;
  int              exp_rd, exp_holds, holds;
  int              errors, store_errors, passed, failed;
  int              wd_cycles = 0;
  logic            running;
  logic            have_pc;
  mips_pkg::word_t last_pc;
  logic [31:0]     lfsr = 32'h168182d7;
  string           cur_test = "none";

  mips dut0
  (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .instr        (instr),
    .memwrite     (memwrite),
    .memaddr      (memaddr),
    .memwritedata (memwritedata),
    .memreaddata  (memreaddata)
  );

  bind mips mips_assertions chk0
  (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .memwrite     (memwrite),
    .memaddr      (memaddr),
    .memwritedata (memwritedata),
    .checking     (mips_tb.running),
    .exp_valid    (mips_tb.exp_valid),
    .exp_head     (mips_tb.exp_head)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Memory models and store monitor
  // ------------------------------------------------------------
  always @(negedge clk)
  begin
    if (memwrite && !reset)
      dmem[memaddr[7:2]] = memwritedata;
    instr       = imem[pc[7:2]];
    memreaddata = dmem[memaddr[7:2]];   // Sees a store from the cycle before
  end

  always @(posedge clk)
  begin
    if (reset)
    begin
      holds   = 0;
      exp_rd  = 0;
      have_pc = 1'b0;
    end
    else
    begin
      if (running && have_pc && pc == last_pc)
        holds++;
      last_pc = pc;
      have_pc = 1'b1;
      if (running && memwrite)
      begin
        if (exp_rd >= exp_q.size())
        begin
          $display("%s: store to %h after the last expected store", cur_test, memaddr);
          store_errors++;
        end
        else
        begin
          if ({memaddr, memwritedata} != exp_q[exp_rd])
          begin
            $display("Fail %s: expected %h actual %h", cur_test, exp_q[exp_rd],
                     {memaddr, memwritedata});
            store_errors++;
          end
          exp_rd++;
        end
      end
    end
    exp_valid <= (exp_rd < exp_q.size());
    exp_head  <= (exp_rd < exp_q.size()) ? exp_q[exp_rd] : '0;
  end

  // Taps 32, 22, 2, 1
  function automatic mips_pkg::word_t rand_bits(input int n);
    mips_pkg::word_t v;
    logic            fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic mips_pkg::word_t r_instr(input logic [5:0] fn, input int rd, input int rs,
                                              input int rt);
    return {`MIPS_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic mips_pkg::word_t i_instr(input logic [5:0] op, input int rt, input int rs,
                                              input mips_pkg::word_t imm);
    return {op, 5'(rs), 5'(rt), imm[15:0]};
  endfunction

  function automatic mips_pkg::word_t alu_ref(input logic [5:0] fn, input mips_pkg::word_t a,
                                              input mips_pkg::word_t b);
    case (fn)
      `MIPS_FN_SUB, `MIPS_FN_SUBU: return a - b;
      `MIPS_FN_AND:                return a & b;
      `MIPS_FN_OR:                 return a | b;
      `MIPS_FN_SLT:                return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:                     return a + b;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Programs
  // ------------------------------------------------------------
  task automatic build_programs();
    // Dependent chain, stores at 0x40
    prog_alu.push_back(i_instr(`MIPS_OP_ORI, 1, 0, 32'h40));
    prog_alu.push_back(i_instr(`MIPS_OP_ADDI, 2, 0, rand_bits(16)));
    prog_alu.push_back(i_instr(`MIPS_OP_ADDIU, 3, 2, rand_bits(16)));
    prog_alu.push_back(r_instr(`MIPS_FN_ADD, 4, 3, 2));
    prog_alu.push_back(r_instr(`MIPS_FN_SUB, 5, 4, 3));
    prog_alu.push_back(r_instr(`MIPS_FN_AND, 6, 5, 4));
    prog_alu.push_back(r_instr(`MIPS_FN_OR, 7, 6, 2));
    prog_alu.push_back(r_instr(`MIPS_FN_SLT, 8, 7, 5));
    prog_alu.push_back(r_instr(`MIPS_FN_ADDU, 9, 8, 7));
    prog_alu.push_back(r_instr(`MIPS_FN_SUBU, 10, 9, 4));
    prog_alu.push_back(i_instr(`MIPS_OP_SW, 10, 1, 32'h0));   // Store data from MEM
    prog_alu.push_back(i_instr(`MIPS_OP_SW, 9, 1, 32'h4));
    prog_alu.push_back(i_instr(`MIPS_OP_SW, 8, 1, 32'h8));
    prog_alu.push_back(i_instr(`MIPS_OP_SW, 5, 1, 32'hc));
    // Two load-use pairs around 0x80
    prog_lu.push_back(i_instr(`MIPS_OP_ORI, 1, 0, 32'h80));
    prog_lu.push_back(i_instr(`MIPS_OP_LW, 2, 1, 32'h0));
    prog_lu.push_back(r_instr(`MIPS_FN_ADD, 3, 2, 2));
    prog_lu.push_back(i_instr(`MIPS_OP_SW, 3, 1, 32'h4));
    prog_lu.push_back(i_instr(`MIPS_OP_LW, 4, 1, 32'h8));
    prog_lu.push_back(i_instr(`MIPS_OP_SW, 4, 1, 32'hc));
    prog_lu.push_back(i_instr(`MIPS_OP_ADDIU, 5, 4, rand_bits(16)));
    prog_lu.push_back(i_instr(`MIPS_OP_SW, 5, 1, 32'h10));
    // r0 writes, then immediates with bit 15 set
    prog_zero.push_back(i_instr(`MIPS_OP_ORI, 1, 0, 32'hc0));
    prog_zero.push_back(i_instr(`MIPS_OP_ADDI, 0, 0, rand_bits(16)));
    prog_zero.push_back(r_instr(`MIPS_FN_ADD, 0, 1, 1));
    prog_zero.push_back(i_instr(`MIPS_OP_SW, 0, 1, 32'h0));
    prog_zero.push_back(i_instr(`MIPS_OP_ORI, 2, 0, 32'h8000 | rand_bits(15)));
    prog_zero.push_back(i_instr(`MIPS_OP_ADDI, 3, 0, 32'h8000 | rand_bits(15)));
    prog_zero.push_back(i_instr(`MIPS_OP_ADDIU, 4, 2, rand_bits(16)));
    prog_zero.push_back(i_instr(`MIPS_OP_SW, 2, 1, 32'h4));
    prog_zero.push_back(i_instr(`MIPS_OP_SW, 3, 1, 32'h8));
    prog_zero.push_back(i_instr(`MIPS_OP_SW, 4, 1, 32'hc));
  endtask

  // Sequential model, one instruction at a time
  task automatic interpret();
    mips_pkg::word_t     ir, a, b, addr;
    mips_pkg::reg_addr_t rs, rt, rd;
    logic [5:0]          op;
    exp_q.delete();
    exp_holds = 0;
    for (int r = 0; r < 32; r++)
      ref_regs[r] = '0;
    for (int i = 0; i < cur_prog.size(); i++)
    begin
      ir   = cur_prog[i];
      op   = ir[31:26];
      rs   = ir[25:21];
      rt   = ir[20:16];
      rd   = ir[15:11];
      a    = ref_regs[rs];
      b    = ref_regs[rt];
      addr = a + {{16{ir[15]}}, ir[15:0]};
      case (op)
        `MIPS_OP_LW:                   ref_regs[rt] = ref_mem[addr[7:2]];
        `MIPS_OP_SW:
        begin
          ref_mem[addr[7:2]] = b;
          exp_q.push_back({addr, b});
        end
        `MIPS_OP_ADDI, `MIPS_OP_ADDIU: ref_regs[rt] = addr;
        `MIPS_OP_ORI:                  ref_regs[rt] = a | {16'h0, ir[15:0]};
        `MIPS_OP_RTYPE:                ref_regs[rd] = alu_ref(ir[5:0], a, b);
        default:                       ref_regs[rd] = a + b;
      endcase
      ref_regs[0] = '0;
      // Load followed by a reader of its rt costs one held cycle
      if (op == `MIPS_OP_LW && i + 1 < cur_prog.size() &&
          (rt == cur_prog[i+1][25:21] || rt == cur_prog[i+1][20:16]))
        exp_holds++;
    end
  endtask

  task automatic run_test(input string name);
    int errs_before;
    errs_before = errors + store_errors + dut0.chk0.fail_count;
    @(negedge clk);
    cur_test = name;
    reset    = 1'b1;
    running  = 1'b0;
    for (int i = 0; i < 64; i++)
    begin
      imem[i]    = (i < cur_prog.size()) ? cur_prog[i] : '0;   // Zero word is a nop
      dmem[i]    = rand_bits(32);
      ref_mem[i] = dmem[i];
    end
    interpret();
    repeat (2) @(negedge clk);
    reset   = 1'b0;
    running = 1'b1;
    while (exp_rd < exp_q.size())
      @(negedge clk);
    running = 1'b0;
    if (holds != exp_holds)
    begin
      $display("Fail %s: expected %0d pc holds, actual %0d", name, exp_holds, holds);
      errors++;
    end
    if (errors + store_errors + dut0.chk0.fail_count == errs_before)
    begin
      $display("Test %s passed", name);
      passed++;
    end
    else
    begin
      $display("Test %s failed", name);
      failed++;
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial
  begin
    reset   = 1'b1;
    running = 1'b0;
    build_programs();
    wd_cycles = 3 * (prog_alu.size() + prog_lu.size() + prog_zero.size()) + 100;
    cur_prog = prog_alu;
    run_test("alu_forward");
    cur_prog = prog_lu;
    run_test("load_use");
    cur_prog = prog_zero;
    run_test("reg_zero_imm");
    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0 && dut0.chk0.fail_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: test %s never finished", cur_test);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
